// File: logic/uparc_params.svh
// back end parameters
// register file geometry, data RAM size and wait-state field width

`ifndef UPARC_PARAMS_SVH
`define UPARC_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// register value width
`define UPARC_REG_WIDTH 32
// register number width, 32 registers
`define UPARC_REGNO_WIDTH 5

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// data RAM words, 6 address bits
`define UPARC_DMEM_DEPTH 64
// extra cycles per access, 0 to 7
`define UPARC_WAIT_WIDTH 3

`endif

// File: logic/uparc_isa_pkg.sv
// ISA types of the back end
// opcodes, register numbers and register values

`default_nettype none

`include "uparc_params.svh"

package uparc_isa_pkg;

  // decoded opcodes
  // three-register ALU group first, then immediate forms, then memory
  typedef enum logic [3:0] {
    NOP  = 4'd0,
    ADD  = 4'd1,
    SUB  = 4'd2,
    AND  = 4'd3,
    OR   = 4'd4,
    XOR  = 4'd5,
    SLT  = 4'd6,
    ADDI = 4'd7,
    LUI  = 4'd8,
    LW   = 4'd9,
    SW   = 4'd10
  } uparc_opcode_e;

  // register number, 0 is the zero register
  typedef logic [`UPARC_REGNO_WIDTH-1:0] uparc_regno_t;

  // register value
  typedef logic [`UPARC_REG_WIDTH-1:0] uparc_word_t;

endpackage

`default_nettype wire

// File: logic/uparc_pipe_pkg.sv
// pipeline types of the back end
// memory stage FSM states and wait counter

`default_nettype none

`include "uparc_params.svh"

package uparc_pipe_pkg;

  // memory stage states
  // IDLE also covers zero-wait accesses
  typedef enum logic {
    IDLE = 1'b0,
    WAIT = 1'b1
  } uparc_mem_state_e;

  // wait-state count
  typedef logic [`UPARC_WAIT_WIDTH-1:0] uparc_wait_t;

endpackage

`default_nettype wire

// File: logic/uparc_ctrl_unit.sv
// control unit
// wait-state register, RAW hazard detection and core stall

`default_nettype none

module uparc_ctrl_unit
  import uparc_isa_pkg::*;
  import uparc_pipe_pkg::*;
(
  input  wire           clk,
  input  wire           nrst,
  // configuration port
  input  wire           i_cfg_we,
  input  uparc_wait_t   i_cfg_wait,
  // stall sources
  input  wire           i_fetch_stall,
  input  wire           i_mem_stall,
  // presented instruction
  input  uparc_opcode_e i_opcode,
  input  uparc_regno_t  i_rs_no,
  input  uparc_regno_t  i_rt_no,
  // destinations in flight
  input  uparc_regno_t  i_ex_rd_no,
  input  uparc_regno_t  i_mem_rd_no,
  input  uparc_regno_t  i_wb_rd_no,
  output uparc_wait_t   o_wait,
  output logic          o_hazard,
  output logic          o_core_stall,
  output logic          o_stall
);

  logic uses_rs;
  logic uses_rt;
  logic rs_hit;
  logic rt_hit;

  // wait-state configuration
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
      o_wait <= '0;
    else if (i_cfg_we)
      o_wait <= i_cfg_wait;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // hazard detection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // rs read by all but NOP and LUI
  assign uses_rs = (i_opcode != NOP) && (i_opcode != LUI);
  // rt read by ALU group and store data
  assign uses_rt = (i_opcode inside {ADD, SUB, AND, OR, XOR, SLT, SW});

  // r0 never hazards
  assign rs_hit = (i_rs_no != '0) &&
    ((i_rs_no == i_ex_rd_no) || (i_rs_no == i_mem_rd_no) || (i_rs_no == i_wb_rd_no));
  assign rt_hit = (i_rt_no != '0) &&
    ((i_rt_no == i_ex_rd_no) || (i_rt_no == i_mem_rd_no) || (i_rt_no == i_wb_rd_no));

  assign o_hazard = (uses_rs && rs_hit) || (uses_rt && rt_hit);

  // hazard kept out of the freeze, later stages must drain
  assign o_core_stall = i_fetch_stall || i_mem_stall;
  // issue held on either
  assign o_stall = o_core_stall || o_hazard;

endmodule

`default_nettype wire

// File: logic/uparc_exec.sv
// execute stage
// ALU and address generation into the exec/mem boundary register

`default_nettype none

`include "uparc_params.svh"

module uparc_exec
  import uparc_isa_pkg::*;
(
  input  wire           clk,
  input  wire           nrst,
  // control
  input  wire           i_core_stall,
  input  wire           i_hazard,
  // decoded instruction
  input  uparc_opcode_e i_opcode,
  input  uparc_regno_t  i_rd_no,
  input  wire [15:0]    i_imm,
  // operands from register file
  input  uparc_word_t   i_rs_val,
  input  uparc_word_t   i_rt_val,
  // to memory access stage
  output uparc_opcode_e o_opcode,
  output uparc_regno_t  o_rd_no,
  output uparc_word_t   o_result,
  output uparc_word_t   o_store_val
);

  uparc_word_t  sext_imm;
  uparc_word_t  alu_res;
  uparc_regno_t dest_no;

  // sign-extended immediate
  assign sext_imm = {{(`UPARC_REG_WIDTH-16){i_imm[15]}}, i_imm};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    case (i_opcode)
      ADD:     alu_res = i_rs_val + i_rt_val;
      SUB:     alu_res = i_rs_val - i_rt_val;
      AND:     alu_res = i_rs_val & i_rt_val;
      OR:      alu_res = i_rs_val | i_rt_val;
      XOR:     alu_res = i_rs_val ^ i_rt_val;
      // signed compare, 0 or 1
      SLT:     alu_res = ($signed(i_rs_val) < $signed(i_rt_val)) ? 'd1 : 'd0;
      // ADDI result and LW/SW address share the adder
      ADDI,
      LW,
      SW:      alu_res = i_rs_val + sext_imm;
      LUI:     alu_res = {i_imm, {(`UPARC_REG_WIDTH-16){1'b0}}};
      default: alu_res = '0;
    endcase
  end

  // store and NOP retire into r0
  assign dest_no = ((i_opcode == SW) || (i_opcode == NOP)) ? '0 : i_rd_no;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // exec/mem register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      o_opcode    <= NOP;
      o_rd_no     <= '0;
      o_result    <= '0;
      o_store_val <= '0;
    end
    else if (!i_core_stall)
    begin
      if (i_hazard)
      begin
        // bubble while the source is in flight
        o_opcode <= NOP;
        o_rd_no  <= '0;
      end
      else
      begin
        o_opcode    <= i_opcode;
        o_rd_no     <= dest_no;
        o_result    <= alu_res;
        o_store_val <= i_rt_val;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/uparc_memacc.sv
// memory access stage
// local data RAM with programmable wait states, loads and stores

`default_nettype none

`include "uparc_params.svh"

module uparc_memacc
  import uparc_isa_pkg::*;
  import uparc_pipe_pkg::*;
(
  input  wire           clk,
  input  wire           nrst,
  // control
  input  wire           i_core_stall,
  input  uparc_wait_t   i_wait,
  // from execute stage
  input  uparc_opcode_e i_opcode,
  input  uparc_regno_t  i_rd_no,
  input  uparc_word_t   i_result,
  input  uparc_word_t   i_store_val,
  // status
  output logic          o_mem_stall,
  output logic          o_busy_store,
  // to writeback stage
  output uparc_regno_t  o_rd_no,
  output uparc_word_t   o_rd_val
);

  localparam int ADDR_W = $clog2(`UPARC_DMEM_DEPTH);

  uparc_word_t      dmem [`UPARC_DMEM_DEPTH];
  uparc_mem_state_e state;
  uparc_wait_t      wait_cnt;
  logic             is_mem;
  logic [ADDR_W-1:0] addr;

  assign is_mem = (i_opcode == LW) || (i_opcode == SW);
  // word address, upper result bits ignored
  assign addr = i_result[ADDR_W-1:0];

  // stall from first cycle of access until count runs out
  // new wait value sampled only when an access starts
  assign o_mem_stall = is_mem && ((state == IDLE) ? (i_wait != '0) : (wait_cnt != '0));

  // store not yet written while it sits at the stage input
  assign o_busy_store = (i_opcode == SW);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // wait-state FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      state    <= IDLE;
      wait_cnt <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (is_mem && (i_wait != '0))
          begin
            state    <= WAIT;
            // first wait cycle is this one
            wait_cnt <= i_wait - 1'b1;
          end
        WAIT:
          if (wait_cnt != '0)
            wait_cnt <= wait_cnt - 1'b1;
          else if (!i_core_stall)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data RAM and mem/wb register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // unstalled edge means the access completes now
  always_ff @(posedge clk)
  begin
    if (!i_core_stall && (i_opcode == SW))
      dmem[addr] <= i_store_val;
  end

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      o_rd_no  <= '0;
      o_rd_val <= '0;
    end
    else if (!i_core_stall)
    begin
      o_rd_no  <= i_rd_no;
      // loads take RAM word, rest pass ALU result
      o_rd_val <= (i_opcode == LW) ? dmem[addr] : i_result;
    end
  end

endmodule

`default_nettype wire

// File: logic/uparc_writeback.sv
// writeback stage
// result register for the register file, frozen on stall, squashed on nullify

`default_nettype none

module uparc_writeback
  import uparc_isa_pkg::*;
(
  input  wire          clk,
  input  wire          nrst,
  // control
  input  wire          i_core_stall,
  input  wire          i_nullify,
  // from memory access stage
  input  uparc_regno_t i_rd_no,
  input  uparc_word_t  i_rd_val,
  // to register file
  output uparc_regno_t o_rd_no,
  output uparc_word_t  o_rd_val
);

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      o_rd_no  <= '0;
      o_rd_val <= '0;
    end
    else if (!i_core_stall)
    begin
      // nullified result lands in r0
      o_rd_no  <= i_nullify ? '0 : i_rd_no;
      o_rd_val <= i_rd_val;
    end
  end

endmodule

`default_nettype wire

// File: logic/uparc_regfile.sv
// register file
// 32 registers, two operand reads, one debug read, one write, r0 fixed at zero

`default_nettype none

`include "uparc_params.svh"

module uparc_regfile
  import uparc_isa_pkg::*;
(
  input  wire          clk,
  input  wire          nrst,
  // read ports
  input  uparc_regno_t i_rs_no,
  input  uparc_regno_t i_rt_no,
  input  uparc_regno_t i_dbg_no,
  // write port
  input  uparc_regno_t i_wr_no,
  input  uparc_word_t  i_wr_val,
  output uparc_word_t  o_rs_val,
  output uparc_word_t  o_rt_val,
  output uparc_word_t  o_dbg_val
);

  localparam int NREG = 2 ** `UPARC_REGNO_WIDTH;

  // no storage for r0
  uparc_word_t regs [1:NREG-1];

  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      for (int i = 1; i < NREG; i++)
        regs[i] <= '0;
    end
    else if (i_wr_no != '0)
      regs[i_wr_no] <= i_wr_val;
  end

  // combinational reads
  // written value visible after the edge
  assign o_rs_val  = (i_rs_no == '0) ? '0 : regs[i_rs_no];
  assign o_rt_val  = (i_rt_no == '0) ? '0 : regs[i_rt_no];
  assign o_dbg_val = (i_dbg_no == '0) ? '0 : regs[i_dbg_no];

endmodule

`default_nettype wire

// File: logic/uparc_backend.sv
// CPU back end top level
// control unit, execute, memory access, writeback and register file

`default_nettype none

module uparc_backend
  import uparc_isa_pkg::*;
  import uparc_pipe_pkg::*;
(
  input  wire           clk,
  input  wire           nrst,
  // issue port
  input  uparc_opcode_e i_opcode,
  input  uparc_regno_t  i_rs_no,
  input  uparc_regno_t  i_rt_no,
  input  uparc_regno_t  i_rd_no,
  input  wire [15:0]    i_imm,
  // pipeline control
  input  wire           i_fetch_stall,
  input  wire           i_nullify,
  // configuration port
  input  wire           i_cfg_we,
  input  uparc_wait_t   i_cfg_wait,
  // debug read
  input  uparc_regno_t  i_dbg_no,
  output logic          o_stall,
  output logic          o_busy,
  output uparc_regno_t  o_wb_rd_no,
  output uparc_word_t   o_wb_rd_val,
  output uparc_word_t   o_dbg_val
);

  // control
  uparc_wait_t   cfg_wait;
  logic          hazard;
  logic          core_stall;
  logic          mem_stall;
  logic          busy_store;
  // operands
  uparc_word_t   rs_val;
  uparc_word_t   rt_val;
  // exec/mem boundary
  uparc_opcode_e ex_opcode;
  uparc_regno_t  ex_rd_no;
  uparc_word_t   ex_result;
  uparc_word_t   ex_store_val;
  // mem/wb boundary
  uparc_regno_t  mem_rd_no;
  uparc_word_t   mem_rd_val;

  // any live destination or pending store
  assign o_busy = (ex_rd_no != '0) || (mem_rd_no != '0) || (o_wb_rd_no != '0) ||
    busy_store;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control unit and stages
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  uparc_ctrl_unit ctrl_unit_i (
    .clk(clk), .nrst(nrst),
    .i_cfg_we(i_cfg_we), .i_cfg_wait(i_cfg_wait),
    .i_fetch_stall(i_fetch_stall), .i_mem_stall(mem_stall),
    .i_opcode(i_opcode), .i_rs_no(i_rs_no), .i_rt_no(i_rt_no),
    .i_ex_rd_no(ex_rd_no), .i_mem_rd_no(mem_rd_no), .i_wb_rd_no(o_wb_rd_no),
    .o_wait(cfg_wait), .o_hazard(hazard), .o_core_stall(core_stall), .o_stall(o_stall)
  );

  uparc_exec exec_i (
    .clk(clk), .nrst(nrst),
    .i_core_stall(core_stall), .i_hazard(hazard),
    .i_opcode(i_opcode), .i_rd_no(i_rd_no), .i_imm(i_imm),
    .i_rs_val(rs_val), .i_rt_val(rt_val),
    .o_opcode(ex_opcode), .o_rd_no(ex_rd_no),
    .o_result(ex_result), .o_store_val(ex_store_val)
  );

  uparc_memacc memacc_i (
    .clk(clk), .nrst(nrst),
    .i_core_stall(core_stall), .i_wait(cfg_wait),
    .i_opcode(ex_opcode), .i_rd_no(ex_rd_no),
    .i_result(ex_result), .i_store_val(ex_store_val),
    .o_mem_stall(mem_stall), .o_busy_store(busy_store),
    .o_rd_no(mem_rd_no), .o_rd_val(mem_rd_val)
  );

  uparc_writeback writeback_i (
    .clk(clk), .nrst(nrst),
    .i_core_stall(core_stall), .i_nullify(i_nullify),
    .i_rd_no(mem_rd_no), .i_rd_val(mem_rd_val),
    .o_rd_no(o_wb_rd_no), .o_rd_val(o_wb_rd_val)
  );

  uparc_regfile regfile_i (
    .clk(clk), .nrst(nrst),
    .i_rs_no(i_rs_no), .i_rt_no(i_rt_no), .i_dbg_no(i_dbg_no),
    .i_wr_no(o_wb_rd_no), .i_wr_val(o_wb_rd_val),
    .o_rs_val(rs_val), .o_rt_val(rt_val), .o_dbg_val(o_dbg_val)
  );

endmodule

`default_nettype wire

// File: tests/tb_uparc_backend.sv
// testbench for the CPU back end
// table-driven instruction sequences checked against a register and RAM model

`default_nettype none

`include "uparc_params.svh"

module tb_uparc_backend
  import uparc_isa_pkg::*;
  import uparc_pipe_pkg::*;
();

  localparam int MAX_INSTR = 256;
  localparam int MAX_TEST  = 16;
  localparam int NREG      = 2 ** `UPARC_REGNO_WIDTH;

  logic          clk;
  logic          nrst;
  uparc_opcode_e opcode;
  uparc_regno_t  rs_no;
  uparc_regno_t  rt_no;
  uparc_regno_t  rd_no;
  logic [15:0]   imm;
  logic          fetch_stall;
  logic          nullify;
  logic          cfg_we;
  uparc_wait_t   cfg_wait;
  uparc_regno_t  dbg_no;
  logic          stall;
  logic          busy;
  uparc_regno_t  wb_rd_no;
  uparc_word_t   wb_rd_val;
  uparc_word_t   dbg_val;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one row per instruction
  uparc_opcode_e tab_op  [MAX_INSTR];
  uparc_regno_t  tab_rs  [MAX_INSTR];
  uparc_regno_t  tab_rt  [MAX_INSTR];
  uparc_regno_t  tab_rd  [MAX_INSTR];
  logic [15:0]   tab_imm [MAX_INSTR];
  // one row per test: slice of instructions plus run conditions
  int            test_first  [MAX_TEST];
  int            test_len    [MAX_TEST];
  uparc_wait_t   test_wait   [MAX_TEST];
  logic          test_null   [MAX_TEST];
  logic [15:0]   test_fstall [MAX_TEST];
  int            n_instr;
  int            n_test;

  // expected architectural state
  uparc_word_t   mdl_reg [NREG];
  uparc_word_t   mdl_mem [`UPARC_DMEM_DEPTH];

  // expected writeback pairs in program order
  uparc_regno_t  exp_wb_no  [$];
  uparc_word_t   exp_wb_val [$];
  uparc_regno_t  last_wb_no;
  uparc_word_t   last_wb_val;

  integer        seed = 32'h8a8c_107d;
  logic [15:0]   fstall_pat;
  int            fstall_idx;
  int            err_cnt;
  int            chk_cnt;
  int            bad_tests;
  int            cycle_cnt;
  int            cycle_limit;

  uparc_backend uparc_backend_i (
    .clk(clk), .nrst(nrst),
    .i_opcode(opcode), .i_rs_no(rs_no), .i_rt_no(rt_no), .i_rd_no(rd_no), .i_imm(imm),
    .i_fetch_stall(fetch_stall), .i_nullify(nullify),
    .i_cfg_we(cfg_we), .i_cfg_wait(cfg_wait), .i_dbg_no(dbg_no),
    .o_stall(stall), .o_busy(busy),
    .o_wb_rd_no(wb_rd_no), .o_wb_rd_val(wb_rd_val), .o_dbg_val(dbg_val)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [15:0] rnd16();
    int v;
    v = $random(seed);
    return v[15:0];
  endfunction

  // random register in lo..31
  function automatic uparc_regno_t rnd_reg(input int lo);
    int v;
    v = $random(seed);
    return uparc_regno_t'(lo + ({v} % (NREG - lo)));
  endfunction

  task automatic begin_test(input uparc_wait_t w, input logic nul, input logic [15:0] fs);
    test_first[n_test]  = n_instr;
    test_len[n_test]    = 0;
    test_wait[n_test]   = w;
    test_null[n_test]   = nul;
    test_fstall[n_test] = fs;
    n_test++;
  endtask

  task automatic add(input uparc_opcode_e op, input uparc_regno_t rs, input uparc_regno_t rt,
                     input uparc_regno_t rd, input logic [15:0] k);
    tab_op[n_instr]  = op;
    tab_rs[n_instr]  = rs;
    tab_rt[n_instr]  = rt;
    tab_rd[n_instr]  = rd;
    tab_imm[n_instr] = k;
    n_instr++;
    test_len[n_test-1]++;
  endtask

  // store/load pairs, two distinct addresses plus a based access
  task automatic add_mem_seq();
    logic [5:0]  a1;
    logic [5:0]  a2;
    logic [15:0] k;
    a1 = rnd16() % 64;
    a2 = a1 + 6'd1 + 6'(rnd16() % 32);
    k  = rnd16();
    // upper immediate bits vary, word address stays
    add(SW, 0, rnd_reg(1), 0, (rnd16() & 16'hffc0) | a1);
    add(LW, 0, 0, 20, (rnd16() & 16'hffc0) | a1);
    add(SW, 0, rnd_reg(1), 0, {10'd0, a2});
    add(LW, 0, 0, 21, {10'd0, a2});
    add(LW, 0, 0, 22, {10'd0, a1});
    add(ADD, 20, 21, 23, 0);
    add(ADDI, 0, 0, 24, rnd16());
    add(SW, 24, 23, 0, k);
    add(LW, 24, 0, 25, k);
  endtask

  // same words on every call with the same arguments
  task automatic add_mixed_seq(input logic [15:0] k1, input logic [15:0] k2,
                               input logic [15:0] a);
    add(ADDI, 1, 0, 26, k1);
    add(LUI, 0, 0, 27, k2);
    add(XOR, 26, 27, 28, 0);
    add(SW, 0, 28, 0, a);
    add(LW, 0, 0, 29, a);
    add(SUB, 29, 26, 30, 0);
    add(SLT, 30, 27, 31, 0);
    add(OR, 31, 28, 26, 0);
  endtask

  task automatic build_table();
    logic [15:0] k1;
    logic [15:0] k2;
    logic [15:0] a;
    n_instr = 0;
    n_test  = 0;
    // random contents for every register
    begin_test(0, 1'b0, 16'h0);
    for (int r = 1; r < NREG; r++)
    begin
      add(LUI, rnd_reg(0), 0, uparc_regno_t'(r), rnd16());
      add(ADDI, uparc_regno_t'(r), 0, uparc_regno_t'(r), rnd16());
    end
    // each ALU opcode on random operands, then r0 targets
    begin_test(0, 1'b0, 16'h0);
    repeat (3)
    begin
      add(ADD, rnd_reg(1), rnd_reg(1), rnd_reg(16), 0);
      add(SUB, rnd_reg(1), rnd_reg(1), rnd_reg(16), 0);
      add(AND, rnd_reg(1), rnd_reg(1), rnd_reg(16), 0);
      add(OR, rnd_reg(1), rnd_reg(1), rnd_reg(16), 0);
      add(XOR, rnd_reg(1), rnd_reg(1), rnd_reg(16), 0);
      add(SLT, rnd_reg(1), rnd_reg(1), rnd_reg(16), 0);
      add(ADDI, rnd_reg(1), 0, rnd_reg(16), rnd16());
      add(LUI, 0, 0, rnd_reg(16), rnd16());
    end
    add(ADD, rnd_reg(1), rnd_reg(1), 0, 0);
    add(LUI, 0, 0, 0, rnd16());
    add(ADDI, rnd_reg(1), 0, 0, rnd16());
    // back-to-back dependencies
    begin_test(0, 1'b0, 16'h0);
    add(ADD, 1, 2, 5, 0);
    add(SUB, 5, 3, 6, 0);
    add(XOR, 6, 5, 7, 0);
    add(ADDI, 7, 0, 7, rnd16());
    add(SLT, 7, 6, 8, 0);
    add(OR, 8, 7, 9, 0);
    add(AND, 9, 9, 10, 0);
    add(ADD, 10, 10, 10, 0);
    // loads and stores over three wait settings
    begin_test(0, 1'b0, 16'h0);
    add_mem_seq();
    begin_test(3, 1'b0, 16'h0);
    add_mem_seq();
    begin_test(7, 1'b0, 16'h0);
    add_mem_seq();
    // squashed results
    begin_test(0, 1'b1, 16'h0);
    add(ADD, 2, 3, 4, 0);
    add(LUI, 0, 0, 5, rnd16());
    add(ADDI, 4, 0, 6, rnd16());
    add(XOR, 6, 5, 7, 0);
    add(SLT, 7, 1, 8, 0);
    // one sequence without and with fetch stall pulses
    k1 = rnd16();
    k2 = rnd16();
    a  = rnd16();
    begin_test(2, 1'b0, 16'h0);
    add_mixed_seq(k1, k2, a);
    begin_test(2, 1'b0, (rnd16() & 16'h3b5d) | 16'h0001);
    add_mixed_seq(k1, k2, a);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // in-order effect of one instruction
  task automatic model_step(input int k, input logic nul);
    uparc_word_t a;
    uparc_word_t b;
    uparc_word_t ext;
    uparc_word_t sum;
    uparc_word_t res;
    logic        wr;
    a   = mdl_reg[tab_rs[k]];
    b   = mdl_reg[tab_rt[k]];
    ext = {{16{tab_imm[k][15]}}, tab_imm[k]};
    sum = a + ext;
    res = '0;
    wr  = 1'b1;
    case (tab_op[k])
      ADD:  res = a + b;
      SUB:  res = a - b;
      AND:  res = a & b;
      OR:   res = a | b;
      XOR:  res = a ^ b;
      SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ADDI: res = sum;
      LUI:  res = {tab_imm[k], 16'h0000};
      LW:   res = mdl_mem[sum % `UPARC_DMEM_DEPTH];
      SW:
      begin
        // stores land even when nullified
        mdl_mem[sum % `UPARC_DMEM_DEPTH] = b;
        wr = 1'b0;
      end
      default: wr = 1'b0;
    endcase
    if (wr && (tab_rd[k] != 0) && !nul)
    begin
      mdl_reg[tab_rd[k]] = res;
      // same pair due at the writeback stage later
      exp_wb_no.push_back(tab_rd[k]);
      exp_wb_val.push_back(res);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic step_fetch_stall();
    fetch_stall = fstall_pat[fstall_idx];
    fstall_idx  = (fstall_idx + 1) % 16;
  endtask

  // entered and left 1 unit after a rising edge
  task automatic issue_instr(input int k);
    logic taken;
    opcode = tab_op[k];
    rs_no  = tab_rs[k];
    rt_no  = tab_rt[k];
    rd_no  = tab_rd[k];
    imm    = tab_imm[k];
    taken  = 1'b0;
    while (!taken)
    begin
      // o_stall settled mid-cycle
      @(negedge clk);
      taken = !stall;
      @(posedge clk);
      #1;
      step_fetch_stall();
    end
  endtask

  task automatic drain_pipe();
    logic idle;
    opcode = NOP;
    rs_no  = '0;
    rt_no  = '0;
    rd_no  = '0;
    imm    = '0;
    idle   = 1'b0;
    while (!idle)
    begin
      @(negedge clk);
      idle = !busy;
      @(posedge clk);
      #1;
      step_fetch_stall();
    end
  endtask

  // every register through the debug port, r0 included
  task automatic check_regs(input int t);
    for (int r = 0; r < NREG; r++)
    begin
      dbg_no = uparc_regno_t'(r);
      @(negedge clk);
      chk_cnt++;
      assert (dbg_val === mdl_reg[r])
      else
      begin
        $display("Mismatch test %0d r%0d o_dbg_val: expected %h, got %h",
                 t, r, mdl_reg[r], dbg_val);
        err_cnt++;
      end
      @(posedge clk);
      #1;
    end
  endtask

  // live writeback pair against the next expected one
  // a frozen stage shows the previous pair again
  task automatic check_writeback();
    logic         hit;
    uparc_regno_t want_no;
    uparc_word_t  want_val;
    hit      = 1'b0;
    want_no  = last_wb_no;
    want_val = last_wb_val;
    if (exp_wb_no.size() != 0)
    begin
      want_no  = exp_wb_no[0];
      want_val = exp_wb_val[0];
      hit      = (wb_rd_no === want_no) && (wb_rd_val === want_val);
    end
    if (hit)
    begin
      last_wb_no  = exp_wb_no.pop_front();
      last_wb_val = exp_wb_val.pop_front();
    end
    chk_cnt++;
    assert (hit || ((wb_rd_no === last_wb_no) && (wb_rd_val === last_wb_val)))
    else
    begin
      $display("Mismatch o_wb_rd_no/o_wb_rd_val: expected %h/%h, got %h/%h",
               want_no, want_val, wb_rd_no, wb_rd_val);
      err_cnt++;
    end
  endtask

  task automatic run_test(input int t);
    int errs_before;
    errs_before = err_cnt;
    // wait register loaded while the pipe is empty
    cfg_we   = 1'b1;
    cfg_wait = test_wait[t];
    @(posedge clk);
    #1;
    cfg_we     = 1'b0;
    nullify    = test_null[t];
    fstall_pat = test_fstall[t];
    fstall_idx = 0;
    step_fetch_stall();
    for (int k = test_first[t]; k < test_first[t] + test_len[t]; k++)
    begin
      issue_instr(k);
      model_step(k, test_null[t]);
    end
    drain_pipe();
    fetch_stall = 1'b0;
    nullify     = 1'b0;
    chk_cnt++;
    assert (exp_wb_no.size() == 0)
    else
    begin
      $display("test %0d: %0d expected results never reached the writeback stage",
               t, exp_wb_no.size());
      err_cnt++;
    end
    exp_wb_no.delete();
    exp_wb_val.delete();
    check_regs(t);
    if (err_cnt != errs_before)
      bad_tests++;
    $display("test %0d: %0d instr, wait %0d, nullify %0b, fetch stall %h, %0d mismatches",
             t, test_len[t], test_wait[t], test_null[t], test_fstall[t], err_cnt - errs_before);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // timeout and main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    cycle_cnt = 0;
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("CHECKS FAILED");
    $finish;
  end

  // writeback stage watched every cycle
  initial
  begin
    last_wb_no  = '0;
    last_wb_val = '0;
    forever
    begin
      @(negedge clk);
      if (wb_rd_no != '0)
        check_writeback();
    end
  end

  initial
  begin
    nrst        = 1'b0;
    opcode      = NOP;
    rs_no       = '0;
    rt_no       = '0;
    rd_no       = '0;
    imm         = '0;
    fetch_stall = 1'b0;
    nullify     = 1'b0;
    cfg_we      = 1'b0;
    cfg_wait    = '0;
    dbg_no      = '0;
    fstall_pat  = '0;
    fstall_idx  = 0;
    err_cnt     = 0;
    chk_cnt     = 0;
    bad_tests   = 0;
    cycle_limit = 0;
    for (int r = 0; r < NREG; r++)
      mdl_reg[r] = '0;
    build_table();
    // 64 cycles per instruction row and per test row
    cycle_limit = (n_instr + n_test) * 64;
    repeat (10) @(posedge clk);
    #1;
    nrst = 1'b1;
    @(negedge clk);
    chk_cnt++;
    assert (!stall && !busy)
    else
    begin
      $display("o_stall or o_busy still high after reset");
      err_cnt++;
    end
    @(posedge clk);
    #1;
    for (int t = 0; t < n_test; t++)
      run_test(t);
    $display("tests %0d, bad tests %0d, checks %0d, mismatches %0d",
             n_test, bad_tests, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: uparc_backend.f
+incdir+logic
logic/uparc_isa_pkg.sv
logic/uparc_pipe_pkg.sv
logic/uparc_ctrl_unit.sv
logic/uparc_exec.sv
logic/uparc_memacc.sv
logic/uparc_writeback.sv
logic/uparc_regfile.sv
logic/uparc_backend.sv
tests/tb_uparc_backend.sv
